//--- verilog/memBusPkg.sv
package memBusPkg;

    localparam int addrWidth = 17;

    typedef logic [addrWidth-1:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // access length in bytes
    typedef logic [2:0] len_t;

    // byte position inside a word
    typedef logic [1:0] beatIdx_t;

    // legal beat counts
    localparam len_t lenByte = 3'd1;
    localparam len_t lenHalf = 3'd2;
    localparam len_t lenWord = 3'd4;

endpackage

//--- verilog/memReqPkg.sv
package memReqPkg;

    // instruction fetch request
    typedef struct packed {
        memBusPkg::addr_t addr;
    } fetchReq_t;

    // load/store request with wdata unused on loads
    typedef struct packed {
        logic             isStore;
        memBusPkg::addr_t addr;
        memBusPkg::len_t  len;
        memBusPkg::word_t wdata;
    } dataReq_t;

    // which client owns the RAM port
    typedef enum logic [1:0] {
        none,
        fetch,
        data
    } client_t;

endpackage

//--- verilog/byteLaneIf.sv
`timescale 1ns/100ps

interface byteLaneIf;

    logic                  start;
    logic                  advance;
    memBusPkg::beatIdx_t   beatIdx;
    logic                  isWrite;
    memBusPkg::len_t       len;

    modport seq (
        output start,
        output advance,
        output beatIdx,
        output isWrite,
        output len
    );

    modport issue (
        input start,
        input advance,
        input beatIdx,
        input isWrite
    );

    modport gather (
        input start,
        input advance,
        input beatIdx,
        input isWrite,
        input len
    );

endinterface

//--- verilog/reqHold.sv
`timescale 1ns/100ps

module reqHold #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,

    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);

    logic     full;
    payload_t held;

    // ready only while empty, so fill and drain never overlap
    assign inReady  = !full;
    assign outValid = full;
    assign outData  = held;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (inValid && inReady) begin
            full <= 1'b1;
        end else if (outValid && outReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            held <= inData;
        end
    end

endmodule

//--- verilog/memSequencer.sv
`timescale 1ns/100ps

module memSequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                ioBufferFull,

    input  logic                fetchValid,
    output logic                fetchReady,
    input  memBusPkg::addr_t    fetchAddr,

    input  logic                dataValid,
    output logic                dataReady,
    input  memReqPkg::dataReq_t dataReq,

    output logic                fetchRespValid,
    input  logic                fetchRespReady,
    output logic                dataRespValid,
    input  logic                dataRespReady,

    byteLaneIf.seq              lane,

    output memBusPkg::addr_t    baseAddr,
    output memBusPkg::word_t    storeWord
);

    typedef enum logic [1:0] {
        idle,
        beat,
        settle,
        respond
    } state_t;

    state_t              state;
    memReqPkg::client_t  owner;
    memReqPkg::client_t  pick;
    memBusPkg::beatIdx_t beatIdx;
    memBusPkg::len_t     len;
    logic                isWrite;
    logic                paused;
    logic                lastBeat;
    logic                respTaken;

    assign paused = !rdy || ioBufferFull;

    // data side wins a tie
    always_comb begin
        pick = memReqPkg::none;
        if (state == idle && !paused) begin
            if (dataValid) begin
                pick = memReqPkg::data;
            end else if (fetchValid) begin
                pick = memReqPkg::fetch;
            end
        end
    end

    assign dataReady  = (pick == memReqPkg::data);
    assign fetchReady = (pick == memReqPkg::fetch);

    assign baseAddr  = (pick == memReqPkg::data) ? dataReq.addr : fetchAddr;
    assign storeWord = dataReq.wdata;

    assign lastBeat = (memBusPkg::len_t'(beatIdx) + 3'd1) == len;

    assign fetchRespValid = (state == respond) && (owner == memReqPkg::fetch);
    assign dataRespValid  = (state == respond) && (owner == memReqPkg::data);
    assign respTaken      = (fetchRespValid && fetchRespReady) ||
                            (dataRespValid && dataRespReady);

    assign lane.start   = (pick != memReqPkg::none);
    assign lane.advance = (state == beat) && !paused;
    assign lane.beatIdx = beatIdx;
    assign lane.isWrite = isWrite;
    assign lane.len     = len;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            owner   <= memReqPkg::none;
            beatIdx <= '0;
            isWrite <= 1'b0;
            len     <= memBusPkg::lenWord;
        end else begin
            case (state)
                idle: begin
                    if (pick != memReqPkg::none) begin
                        state   <= beat;
                        owner   <= pick;
                        beatIdx <= '0;
                        if (pick == memReqPkg::data) begin
                            isWrite <= dataReq.isStore;
                            len     <= dataReq.len;
                        end else begin
                            isWrite <= 1'b0;
                            len     <= memBusPkg::lenWord;
                        end
                    end
                end
                beat: begin
                    if (!paused) begin
                        beatIdx <= beatIdx + 2'd1;
                        if (lastBeat) begin
                            state <= settle;
                        end
                    end
                end
                // last read byte lands here
                settle: begin
                    if (!paused) begin
                        state <= respond;
                    end
                end
                respond: begin
                    if (respTaken) begin
                        state <= idle;
                        owner <= memReqPkg::none;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/beatIssuer.sv
`timescale 1ns/100ps

module beatIssuer (
    input  logic              clk,
    input  logic              rst,

    byteLaneIf.issue          lane,

    input  memBusPkg::addr_t  baseAddr,
    input  memBusPkg::word_t  storeWord,

    output memBusPkg::addr_t  memAddr,
    output logic              memWe,
    output memBusPkg::byte_t  memWdata
);

    memBusPkg::addr_t             base;
    memBusPkg::byte_t [3:0]       storeBytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            base <= '0;
        end else if (lane.start) begin
            base <= baseAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (lane.start) begin
            storeBytes <= storeWord;
        end
    end

    assign memAddr  = base + memBusPkg::addr_t'(lane.beatIdx);
    assign memWdata = storeBytes[lane.beatIdx];

    // a paused beat never writes
    assign memWe = lane.advance && lane.isWrite;

endmodule

//--- verilog/loadAssembler.sv
`timescale 1ns/100ps

module loadAssembler (
    input  logic              clk,
    input  logic              rst,

    byteLaneIf.gather         lane,

    input  memBusPkg::byte_t  memRdata,
    output memBusPkg::word_t  word
);

    memBusPkg::byte_t [3:0]   gathered;
    memBusPkg::beatIdx_t      prevLane;
    memBusPkg::word_t         mask;
    logic                     pending;

    // beat counter has already moved on when the byte comes back
    assign prevLane = lane.beatIdx - 2'd1;

    always_ff @(posedge clk) begin
        if (rst || lane.start) begin
            pending  <= 1'b0;
            gathered <= '0;
        end else begin
            pending <= lane.advance && !lane.isWrite;
            if (pending) begin
                gathered[prevLane] <= memRdata;
            end
        end
    end

    // zero extend by length
    always_comb begin
        case (lane.len)
            memBusPkg::lenByte: mask = 32'h0000_00ff;
            memBusPkg::lenHalf: mask = 32'h0000_ffff;
            default:            mask = 32'hffff_ffff;
        endcase
    end

    assign word = gathered & mask;

endmodule

//--- verilog/memController.sv
`timescale 1ns/100ps

module memController (
    input  logic              clk,
    input  logic              rst,

    input  logic              fetchReqValid,
    output logic              fetchReqReady,
    input  memBusPkg::addr_t  fetchAddr,
    output logic              fetchRespValid,
    input  logic              fetchRespReady,
    output memBusPkg::word_t  fetchInst,

    input  logic              dataReqValid,
    output logic              dataReqReady,
    input  logic              dataIsStore,
    input  memBusPkg::addr_t  dataAddr,
    input  memBusPkg::len_t   dataLen,
    input  memBusPkg::word_t  dataWdata,
    output logic              dataRespValid,
    input  logic              dataRespReady,
    output memBusPkg::word_t  dataRdata,

    output memBusPkg::addr_t  memAddr,
    output logic              memWe,
    output memBusPkg::byte_t  memWdata,
    input  memBusPkg::byte_t  memRdata,

    input  logic              rdy,
    input  logic              ioBufferFull
);

    memReqPkg::fetchReq_t fetchIn;
    memReqPkg::fetchReq_t fetchHeld;
    memReqPkg::dataReq_t  dataIn;
    memReqPkg::dataReq_t  dataHeld;
    logic                 fetchValid;
    logic                 fetchReady;
    logic                 dataValid;
    logic                 dataReady;
    memBusPkg::addr_t     baseAddr;
    memBusPkg::word_t     storeWord;
    memBusPkg::word_t     loadWord;

    byteLaneIf lane ();

    assign fetchIn.addr = fetchAddr;
    assign dataIn = '{isStore: dataIsStore, addr: dataAddr, len: dataLen, wdata: dataWdata};

    reqHold #(.payload_t(memReqPkg::fetchReq_t)) fetchHold (
        .clk(clk), .rst(rst),
        .inValid(fetchReqValid), .inReady(fetchReqReady), .inData(fetchIn),
        .outValid(fetchValid), .outReady(fetchReady), .outData(fetchHeld)
    );

    reqHold #(.payload_t(memReqPkg::dataReq_t)) dataHold (
        .clk(clk), .rst(rst),
        .inValid(dataReqValid), .inReady(dataReqReady), .inData(dataIn),
        .outValid(dataValid), .outReady(dataReady), .outData(dataHeld)
    );

    memSequencer sequencer (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchValid(fetchValid), .fetchReady(fetchReady), .fetchAddr(fetchHeld.addr),
        .dataValid(dataValid), .dataReady(dataReady), .dataReq(dataHeld),
        .fetchRespValid(fetchRespValid), .fetchRespReady(fetchRespReady),
        .dataRespValid(dataRespValid), .dataRespReady(dataRespReady),
        .lane(lane.seq),
        .baseAddr(baseAddr), .storeWord(storeWord)
    );

    beatIssuer issuer (
        .clk(clk), .rst(rst),
        .lane(lane.issue),
        .baseAddr(baseAddr), .storeWord(storeWord),
        .memAddr(memAddr), .memWe(memWe), .memWdata(memWdata)
    );

    loadAssembler assembler (
        .clk(clk), .rst(rst),
        .lane(lane.gather),
        .memRdata(memRdata),
        .word(loadWord)
    );

    // only one client owns the response, so both can share the word
    assign fetchInst = loadWord;
    assign dataRdata = loadWord;

endmodule

//--- tb/memChecker.sv
`timescale 1ns/100ps

module memChecker (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             ioBufferFull,
    input  logic             fetchReqValid,
    input  logic             fetchReqReady,
    input  memBusPkg::addr_t fetchAddr,
    input  logic             fetchRespValid,
    input  logic             fetchRespReady,
    input  memBusPkg::word_t fetchInst,
    input  logic             dataReqValid,
    input  logic             dataReqReady,
    input  logic             dataIsStore,
    input  memBusPkg::addr_t dataAddr,
    input  memBusPkg::len_t  dataLen,
    input  memBusPkg::word_t dataWdata,
    input  logic             dataRespValid,
    input  logic             dataRespReady,
    input  memBusPkg::word_t dataRdata,
    input  memBusPkg::addr_t memAddr,
    input  logic             memWe,
    input  memBusPkg::byte_t memWdata,
    output int               tests,
    output int               errors
);

    // reference copy of the RAM that the testbench preloads
    memBusPkg::byte_t refMem [0:(1 << memBusPkg::addrWidth) - 1];

    // requests sitting in the DUT input buffers
    logic             fetchFull = 1'b0;
    logic             dataFull = 1'b0;
    memBusPkg::addr_t fetchPendAddr;
    logic             dataPendStore;
    memBusPkg::addr_t dataPendAddr;
    memBusPkg::len_t  dataPendLen;
    memBusPkg::word_t dataPendWdata;

    // access in flight
    logic             active = 1'b0;
    logic             actData;
    logic             actStore;
    memBusPkg::addr_t actAddr;
    memBusPkg::len_t  actLen;
    memBusPkg::word_t actWdata;
    memBusPkg::word_t expWord;
    logic             respSeen;
    int               cnt;
    int               writes;
    int               errAtStart;

    task automatic flagValue(input string sig, input memBusPkg::word_t exp,
                             input memBusPkg::word_t got);
        $display("Fail at %0t: %s expected %h got %h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic flagEvent(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic checkBit(input string sig, input logic exp, input logic got);
        if (got !== exp) begin
            flagValue(sig, {31'd0, exp}, {31'd0, got});
        end
    endtask

    task automatic startNext();
        if (dataFull) begin
            actData  = 1'b1;
            actStore = dataPendStore;
            actAddr  = dataPendAddr;
            actLen   = dataPendLen;
            actWdata = dataPendWdata;
            dataFull = 1'b0;
        end else begin
            actData   = 1'b0;
            actStore  = 1'b0;
            actAddr   = fetchPendAddr;
            actLen    = memBusPkg::lenWord;
            actWdata  = '0;
            fetchFull = 1'b0;
        end
        // stores answer with zero while loads are little endian and zero extended
        expWord = '0;
        if (!actStore) begin
            for (int k = 0; k < int'(actLen); k++) begin
                expWord = expWord | (memBusPkg::word_t'(refMem[actAddr +
                          memBusPkg::addr_t'(k)]) << (8 * k));
            end
        end
        active     = 1'b1;
        respSeen   = 1'b0;
        cnt        = 0;
        writes     = 0;
        errAtStart = errors;
    endtask

    task automatic checkWrite(input logic paused);
        memBusPkg::addr_t expAddr;
        memBusPkg::byte_t expByte;
        if (!active || !actStore || respSeen || writes >= int'(actLen)) begin
            flagEvent("memWe high outside a store beat");
        end else if (paused) begin
            flagEvent("memWe high during a pause cycle");
        end else begin
            expAddr = actAddr + memBusPkg::addr_t'(writes);
            expByte = memBusPkg::byte_t'(actWdata >> (8 * writes));
            if (memAddr !== expAddr) begin
                flagValue("memAddr", memBusPkg::word_t'(expAddr), memBusPkg::word_t'(memAddr));
            end
            if (memWdata !== expByte) begin
                flagValue("memWdata", memBusPkg::word_t'(expByte), memBusPkg::word_t'(memWdata));
            end
            refMem[expAddr] = expByte;
            writes++;
        end
    endtask

    task automatic finishTest();
        string kind;
        if (!actData) begin
            kind = "fetch";
        end else if (actStore) begin
            kind = "store";
        end else begin
            kind = "load";
        end
        if (actStore && writes != int'(actLen)) begin
            flagEvent($sformatf("store wrote %0d bytes instead of %0d", writes, actLen));
        end
        tests++;
        $display("test %0d %s addr %h len %0d latency %0d: %s", tests, kind, actAddr,
                 actLen, cnt, (errors == errAtStart) ? "ok" : "mismatch");
        active = 1'b0;
    endtask

    always @(posedge clk) begin
        logic             paused;
        logic             rv;
        logic             rr;
        memBusPkg::word_t got;
        paused = !rdy || ioBufferFull;
        if (rst) begin
            fetchFull = 1'b0;
            dataFull  = 1'b0;
            active    = 1'b0;
            tests     = 0;
            errors    = 0;
        end else begin
            // a buffer is ready exactly while it holds nothing
            checkBit("fetchReqReady", !fetchFull, fetchReqReady);
            checkBit("dataReqReady", !dataFull, dataReqReady);
            if (fetchRespValid && !(active && !actData)) begin
                flagEvent("fetchRespValid high with no fetch in flight");
            end
            if (dataRespValid && !(active && actData)) begin
                flagEvent("dataRespValid high with no load or store in flight");
            end
            if (memWe) begin
                checkWrite(paused);
            end
            if (active) begin
                rv  = actData ? dataRespValid : fetchRespValid;
                rr  = actData ? dataRespReady : fetchRespReady;
                got = actData ? dataRdata : fetchInst;
                if (rv) begin
                    if (!respSeen) begin
                        respSeen = 1'b1;
                        if (cnt != int'(actLen) + 1) begin
                            flagValue("response latency", memBusPkg::word_t'(int'(actLen) + 1),
                                      memBusPkg::word_t'(cnt));
                        end
                    end
                    if (got !== expWord) begin
                        flagValue(actData ? "dataRdata" : "fetchInst", expWord, got);
                    end
                    if (rr) begin
                        finishTest();
                    end
                end else if (respSeen) begin
                    flagEvent("response valid dropped before it was taken");
                end else if (!paused) begin
                    cnt++;
                end
            end else if (!paused && (dataFull || fetchFull)) begin
                // idle controller grants here with data first
                startNext();
            end
            if (fetchReqValid && fetchReqReady) begin
                fetchFull     = 1'b1;
                fetchPendAddr = fetchAddr;
            end
            if (dataReqValid && dataReqReady) begin
                dataFull      = 1'b1;
                dataPendStore = dataIsStore;
                dataPendAddr  = dataAddr;
                dataPendLen   = dataLen;
                dataPendWdata = dataWdata;
            end
        end
    end

endmodule

//--- tb/tbMemController.sv
`timescale 1ns/100ps

module tbMemController;

    localparam int clkPeriod = 8;
    localparam int ramSize = 1 << memBusPkg::addrWidth;
    localparam int clientFetch = 0;
    localparam int clientData = 1;
    localparam int clientBoth = 2;

    typedef struct {
        int               client;
        logic             isStore;
        memBusPkg::addr_t addr;
        memBusPkg::len_t  len;
        memBusPkg::word_t wdata;
        logic [7:0]       pause;
        int               delay;
    } entry_t;

    entry_t stimTable[$];

    logic             clk = 1'b0;
    logic             rst;
    logic             fetchReqValid;
    logic             fetchReqReady;
    memBusPkg::addr_t fetchAddr;
    logic             fetchRespValid;
    logic             fetchRespReady;
    memBusPkg::word_t fetchInst;
    logic             dataReqValid;
    logic             dataReqReady;
    logic             dataIsStore;
    memBusPkg::addr_t dataAddr;
    memBusPkg::len_t  dataLen;
    memBusPkg::word_t dataWdata;
    logic             dataRespValid;
    logic             dataRespReady;
    memBusPkg::word_t dataRdata;
    memBusPkg::addr_t memAddr;
    logic             memWe;
    memBusPkg::byte_t memWdata;
    memBusPkg::byte_t memRdata = '0;
    logic             rdy = 1'b1;
    logic             ioBufferFull = 1'b0;
    logic [7:0]       pauseMask = '0;
    logic [2:0]       cycIdx = '0;
    int               tests;
    int               errors;
    memBusPkg::byte_t ram [0:ramSize - 1];

    always #(clkPeriod / 2) clk = !clk;

    memController dut_i (.*);

    memChecker memCheck (.*);

    // one-cycle synchronous RAM
    always @(posedge clk) begin
        if (memWe) begin
            ram[memAddr] <= memWdata;
        end
        memRdata <= ram[memAddr];
    end

    // even mask slots pull rdy low, odd slots raise ioBufferFull
    always @(posedge clk) begin
        cycIdx       <= cycIdx + 3'd1;
        rdy          <= !(pauseMask[cycIdx] && !cycIdx[0]);
        ioBufferFull <= pauseMask[cycIdx] && cycIdx[0];
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic addEntry(input int client, input logic isStore, input memBusPkg::addr_t addr,
                            input memBusPkg::len_t len, input memBusPkg::word_t wdata,
                            input logic [7:0] pause, input int delay);
        entry_t e;
        e.client  = client;
        e.isStore = isStore;
        e.addr    = addr;
        e.len     = len;
        e.wdata   = wdata;
        e.pause   = pause;
        e.delay   = delay;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        addEntry(clientFetch, 1'b0, 17'h00100, 3'd4, 32'h0, 8'h00, 0);
        addEntry(clientFetch, 1'b0, 17'h1f0c2, 3'd4, 32'h0, 8'h00, 1);
        addEntry(clientData, 1'b0, 17'h00301, 3'd1, 32'h0, 8'h00, 0);
        addEntry(clientData, 1'b0, 17'h00302, 3'd2, 32'h0, 8'h00, 0);
        addEntry(clientData, 1'b0, 17'h00304, 3'd4, 32'h0, 8'h00, 0);
        addEntry(clientData, 1'b1, 17'h00400, 3'd1, 32'hdeadbeef, 8'h00, 0);
        addEntry(clientData, 1'b0, 17'h00400, 3'd4, 32'h0, 8'h00, 0);
        addEntry(clientData, 1'b1, 17'h00410, 3'd2, 32'h12345678, 8'h00, 0);
        addEntry(clientData, 1'b0, 17'h00410, 3'd4, 32'h0, 8'h00, 0);
        addEntry(clientData, 1'b1, 17'h00420, 3'd4, 32'hcafef00d, 8'h00, 0);
        addEntry(clientData, 1'b0, 17'h0041f, 3'd4, 32'h0, 8'h00, 0);
        // both clients in the same cycle
        addEntry(clientBoth, 1'b0, 17'h00500, 3'd4, 32'h0, 8'h00, 0);
        addEntry(clientBoth, 1'b1, 17'h00600, 3'd4, 32'h89abcdef, 8'h00, 0);
        addEntry(clientFetch, 1'b0, 17'h00700, 3'd4, 32'h0, 8'ha6, 0);
        addEntry(clientData, 1'b1, 17'h00800, 3'd2, 32'h00005a3c, 8'h6d, 0);
        addEntry(clientData, 1'b0, 17'h007ff, 3'd4, 32'h0, 8'h9b, 0);
        addEntry(clientData, 1'b0, 17'h00801, 3'd1, 32'h0, 8'h77, 2);
        addEntry(clientData, 1'b0, 17'h00900, 3'd2, 32'h0, 8'h00, 5);
        addEntry(clientBoth, 1'b1, 17'h00a00, 3'd1, 32'h000000c3, 8'h49, 4);
        addEntry(clientFetch, 1'b0, 17'h00a00, 3'd4, 32'h0, 8'h22, 3);
    endtask

    task automatic takeResponse(input logic isData, input int delay);
        do begin
            @(posedge clk);
        end while (isData ? !dataRespValid : !fetchRespValid);
        repeat (delay) @(posedge clk);
        if (isData) begin
            dataRespReady <= 1'b1;
        end else begin
            fetchRespReady <= 1'b1;
        end
        @(posedge clk);
        dataRespReady  <= 1'b0;
        fetchRespReady <= 1'b0;
    endtask

    task automatic runEntry(input entry_t e);
        @(posedge clk);
        pauseMask <= e.pause;
        if (e.client != clientData) begin
            fetchReqValid <= 1'b1;
            fetchAddr     <= e.addr;
        end
        if (e.client != clientFetch) begin
            dataReqValid <= 1'b1;
            dataIsStore  <= e.isStore;
            dataAddr     <= e.addr;
            dataLen      <= e.len;
            dataWdata    <= e.wdata;
        end
        // buffers are empty between entries, so this edge takes the request
        @(posedge clk);
        fetchReqValid <= 1'b0;
        dataReqValid  <= 1'b0;
        if (e.client != clientFetch) begin
            takeResponse(1'b1, e.delay);
        end
        if (e.client != clientData) begin
            takeResponse(1'b0, e.delay);
        end
        pauseMask <= '0;
    endtask

    initial begin
        int limit;
        #1;
        limit = (stimTable.size() * 40 + 16) * clkPeriod;
        #(limit);
        $display("timeout: the controller stopped answering before the table was done");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] seed;
        int          expectResp;
        rst            = 1'b1;
        fetchReqValid  = 1'b0;
        fetchAddr      = '0;
        fetchRespReady = 1'b0;
        dataReqValid   = 1'b0;
        dataIsStore    = 1'b0;
        dataAddr       = '0;
        dataLen        = memBusPkg::lenWord;
        dataWdata      = '0;
        dataRespReady  = 1'b0;
        seed = 32'hcb4a;
        for (int a = 0; a < ramSize; a++) begin
            seed = lcgNext(seed);
            ram[memBusPkg::addr_t'(a)] = seed[23:16];
            memCheck.refMem[memBusPkg::addr_t'(a)] = seed[23:16];
        end
        buildTable();
        expectResp = 0;
        foreach (stimTable[i]) begin
            expectResp += (stimTable[i].client == clientBoth) ? 2 : 1;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        foreach (stimTable[i]) begin
            runEntry(stimTable[i]);
        end
        repeat (4) @(posedge clk);
        if (tests != expectResp) begin
            $display("only %0d of %0d responses came back", tests, expectResp);
        end
        $display("%0d tests done, %0d errors", tests, errors);
        if (errors == 0 && tests == expectResp) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/memBusPkg.sv
verilog/memReqPkg.sv
verilog/byteLaneIf.sv
verilog/reqHold.sv
verilog/memSequencer.sv
verilog/beatIssuer.sv
verilog/loadAssembler.sv
verilog/memController.sv
tb/memChecker.sv
tb/tbMemController.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbMemController -f src.f

out=$(./obj_dir/VtbMemController)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
